//--- Makefile
VERILATOR ?= verilator
TOP ?= peripherals_tb
SEED_FLAGS ?= +verilator+seed+1
BUILD_DIR ?= build
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT := All checks passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  build  compile the design and testbench with Verilator"
	@echo "  test   build, run the simulation and check for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f list.f --Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/chipset_pkg.sv
package chipset_pkg;

	// cpu side bus widths
	typedef logic [19:0] addr_t;
	typedef logic [7:0] data_t;
	typedef logic [15:0] io_port_t;

	// msb set means the access hit an ems window
	typedef logic [20:0] phys_addr_t;

	// ems mapper
	typedef logic [5:0] ems_page_t;
	typedef logic [1:0] ems_index_t;
	typedef logic [1:0] frame_sel_t;

	// default port bases
	localparam io_port_t DEFAULT_EMS_BASE = 16'h0260;
	localparam io_port_t DEFAULT_LPT_BASE = 16'h0378;

	// page frame segment nibbles
	localparam logic [3:0] FRAME_BASE_A000 = 4'ha;
	localparam logic [3:0] FRAME_BASE_C000 = 4'hc;
	localparam logic [3:0] FRAME_BASE_D000 = 4'hd;

	// ems register write codes
	localparam data_t EMS_DISABLE_CODE = 8'hff;
	localparam data_t EMS_PAGE_LIMIT = 8'h80;

	// readback of a disabled page
	localparam data_t EMS_DISABLED_READ = 8'hff;

	// printer latch value out of reset
	localparam data_t LPT_RESET_VALUE = 8'hff;

endpackage

//--- hw/chipset_readback.sv
`timescale 1ns/1ps

module chipset_readback import chipset_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  data_t data_i,
	input  logic  io_read_n_i,
	input  logic  io_write_n_i,
	input  logic  ems_sel_i,
	input  logic  lpt_sel_i,
	input  data_t ems_read_data_i,
	output data_t data_bus_o,
	output logic  data_from_chipset_o
);

	data_t lpt_data_q;
	logic ems_read;
	logic lpt_read;

	// printer data latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data_q <= LPT_RESET_VALUE;
		end else if (lpt_sel_i && !io_write_n_i) begin
			lpt_data_q <= data_i;
		end
	end

	assign ems_read = ems_sel_i & ~io_read_n_i;
	assign lpt_read = lpt_sel_i & ~io_read_n_i;

	// ems registers win over the latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_bus_o <= '0;
			data_from_chipset_o <= 1'b0;
		end else if (ems_read) begin
			data_bus_o <= ems_read_data_i;
			data_from_chipset_o <= 1'b1;
		end else if (lpt_read) begin
			data_bus_o <= lpt_data_q;
			data_from_chipset_o <= 1'b1;
		end else begin
			data_bus_o <= '0;
			data_from_chipset_o <= 1'b0;
		end
	end

endmodule

//--- hw/ems_mapper.sv
`timescale 1ns/1ps

module ems_mapper import chipset_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  addr_t      address_i,
	input  logic       io_read_n_i,
	input  logic       io_write_n_i,
	input  data_t      data_i,
	input  logic       ems_sel_i,
	input  frame_sel_t frame_sel_i,
	output data_t      ems_read_data_o,
	output phys_addr_t mem_addr_o
);

	ems_page_t page_q [4];
	logic [3:0] page_en_q;

	ems_index_t reg_index;
	ems_page_t next_page;
	logic next_en;
	logic write_hit;

	// write pipeline stage
	logic wr_valid_q;
	ems_index_t wr_index_q;
	ems_page_t wr_page_q;
	logic wr_en_q;

	logic io_request;
	logic [3:0] frame_base;
	ems_index_t slot;
	logic frame_hit;

	assign reg_index = address_i[1:0];
	assign write_hit = ems_sel_i & ~io_write_n_i;

	// new register contents from the written byte
	always_comb begin
		next_page = page_q[reg_index];
		next_en = page_en_q[reg_index];
		if (data_i == EMS_DISABLE_CODE) begin
			next_en = 1'b0;
		end else if (data_i < EMS_PAGE_LIMIT) begin
			next_page = data_i[5:0];
			next_en = 1'b1;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_valid_q <= 1'b0;
		end else begin
			wr_valid_q <= write_hit;
		end
	end

	always_ff @(posedge clock) begin
		wr_index_q <= reg_index;
		wr_page_q <= next_page;
		wr_en_q <= next_en;
	end

	// register update one edge after the write is sampled
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			page_q <= '{default: '0};
			page_en_q <= 4'b0000;
		end else if (wr_valid_q) begin
			page_q[wr_index_q] <= wr_page_q;
			page_en_q[wr_index_q] <= wr_en_q;
		end
	end

	always_comb begin
		if (page_en_q[reg_index]) begin
			ems_read_data_o = {2'b00, page_q[reg_index]};
		end else begin
			ems_read_data_o = EMS_DISABLED_READ;
		end
	end

	assign io_request = ~io_read_n_i | ~io_write_n_i;

	always_comb begin
		case (frame_sel_i)
			2'd0: begin
				frame_base = FRAME_BASE_A000;
			end
			2'd1: begin
				frame_base = FRAME_BASE_C000;
			end
			default: begin
				frame_base = FRAME_BASE_D000;
			end
		endcase
	end

	// 16k slot inside the 64k frame
	assign slot = address_i[15:14];

	assign frame_hit = ~io_request & (address_i[19:16] == frame_base) & page_en_q[slot];

	always_comb begin
		if (frame_hit) begin
			mem_addr_o = {1'b1, page_q[slot], address_i[13:0]};
		end else begin
			mem_addr_o = {1'b0, address_i};
		end
	end

endmodule

//--- hw/io_decoder.sv
`timescale 1ns/1ps

module io_decoder import chipset_pkg::*; #(
	parameter io_port_t EMS_BASE = DEFAULT_EMS_BASE,
	parameter io_port_t LPT_BASE = DEFAULT_LPT_BASE
) (
	input  addr_t address_i,
	input  logic  address_enable_n_i,
	input  logic  io_read_n_i,
	input  logic  io_write_n_i,
	input  logic  ems_enabled_i,
	output logic  dma_cs_n_o,
	output logic  pic_cs_n_o,
	output logic  pit_cs_n_o,
	output logic  ppi_cs_n_o,
	output logic  dma_page_cs_n_o,
	output logic  mem_select_n_o,
	output logic  ems_sel_o,
	output logic  lpt_sel_o
);

	logic io_request;
	logic io_cycle;
	logic low_io_space;
	logic [4:0] cs_active;

	assign io_request = ~io_read_n_i | ~io_write_n_i;

	// cpu owns the bus and is doing i/o
	assign io_cycle = ~address_enable_n_i & io_request;

	// xt chips only decode the first 256 ports
	assign low_io_space = io_cycle & ~address_i[9] & ~address_i[8];

	// one select per 32 port group
	always_comb begin
		cs_active = 5'b00000;
		if (low_io_space) begin
			case (address_i[7:5])
				3'd0: begin
					cs_active[0] = 1'b1;
				end
				3'd1: begin
					cs_active[1] = 1'b1;
				end
				3'd2: begin
					cs_active[2] = 1'b1;
				end
				3'd3: begin
					cs_active[3] = 1'b1;
				end
				3'd4: begin
					cs_active[4] = 1'b1;
				end
				default: begin
					cs_active = 5'b00000;
				end
			endcase
		end
	end

	assign dma_cs_n_o = ~cs_active[0];
	assign pic_cs_n_o = ~cs_active[1];
	assign pit_cs_n_o = ~cs_active[2];
	assign ppi_cs_n_o = ~cs_active[3];
	assign dma_page_cs_n_o = ~cs_active[4];

	// any non i/o cycle with the bus owned is a memory cycle
	assign mem_select_n_o = ~(~address_enable_n_i & ~io_request);

	// four consecutive ems page register ports
	assign ems_sel_o = io_cycle & ems_enabled_i & (address_i[15:2] == EMS_BASE[15:2]);

	assign lpt_sel_o = io_cycle & (address_i[15:0] == LPT_BASE);

endmodule

//--- hw/peripherals_top.sv
`timescale 1ns/1ps

module peripherals_top import chipset_pkg::*; #(
	parameter io_port_t EMS_BASE = DEFAULT_EMS_BASE,
	parameter io_port_t LPT_BASE = DEFAULT_LPT_BASE
) (
	input  logic       clock,
	input  logic       reset,
	input  addr_t      address_i,
	input  data_t      data_i,
	input  logic       io_read_n_i,
	input  logic       io_write_n_i,
	// memory read strobe is not used inside the chipset
	input  logic       memory_read_n_i,
	input  logic       address_enable_n_i,
	input  logic       ems_enabled_i,
	input  frame_sel_t frame_sel_i,
	output logic       dma_cs_n_o,
	output logic       pic_cs_n_o,
	output logic       pit_cs_n_o,
	output logic       ppi_cs_n_o,
	output logic       dma_page_cs_n_o,
	output logic       mem_select_n_o,
	output phys_addr_t mem_addr_o,
	output data_t      data_bus_o,
	output logic       data_from_chipset_o
);

	logic ems_sel;
	logic lpt_sel;
	data_t ems_read_data;

	io_decoder #(
		.EMS_BASE(EMS_BASE),
		.LPT_BASE(LPT_BASE)
	) u_io_decoder (
		.address_i(address_i),
		.address_enable_n_i(address_enable_n_i),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.ems_enabled_i(ems_enabled_i),
		.dma_cs_n_o(dma_cs_n_o),
		.pic_cs_n_o(pic_cs_n_o),
		.pit_cs_n_o(pit_cs_n_o),
		.ppi_cs_n_o(ppi_cs_n_o),
		.dma_page_cs_n_o(dma_page_cs_n_o),
		.mem_select_n_o(mem_select_n_o),
		.ems_sel_o(ems_sel),
		.lpt_sel_o(lpt_sel)
	);

	ems_mapper u_ems_mapper (
		.clock(clock),
		.reset(reset),
		.address_i(address_i),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.data_i(data_i),
		.ems_sel_i(ems_sel),
		.frame_sel_i(frame_sel_i),
		.ems_read_data_o(ems_read_data),
		.mem_addr_o(mem_addr_o)
	);

	chipset_readback u_chipset_readback (
		.clock(clock),
		.reset(reset),
		.data_i(data_i),
		.io_read_n_i(io_read_n_i),
		.io_write_n_i(io_write_n_i),
		.ems_sel_i(ems_sel),
		.lpt_sel_i(lpt_sel),
		.ems_read_data_i(ems_read_data),
		.data_bus_o(data_bus_o),
		.data_from_chipset_o(data_from_chipset_o)
	);

endmodule

//--- list.f
+incdir+tests
hw/chipset_pkg.sv
hw/io_decoder.sv
hw/ems_mapper.sv
hw/chipset_readback.sv
hw/peripherals_top.sv
tests/peripherals_tb.sv

//--- tests/peripherals_model.svh
`ifndef PERIPHERALS_MODEL_SVH
`define PERIPHERALS_MODEL_SVH

// reference register state and the ems write in flight
logic [5:0] m_page [4];
logic [3:0] m_en;
data_t m_lpt;
logic m_wr_valid;
logic [1:0] m_wr_idx;
logic [5:0] m_wr_page;
logic m_wr_en;
data_t m_bus;
logic m_flag;

function automatic logic io_cycle_now();
	return !address_enable_n && (!io_read_n || !io_write_n);
endfunction

function automatic logic ems_selected();
	return io_cycle_now() && ems_enabled && (address[15:2] == EMS_PORT[15:2]);
endfunction

function automatic logic lpt_selected();
	return io_cycle_now() && (address[15:0] == LPT_PORT);
endfunction

// bit n low selects group n of the low 256 ports
function automatic logic [4:0] expected_chip_selects();
	logic [4:0] cs;
	cs = 5'b11111;
	if (io_cycle_now() && address[9:8] == 2'b00 && address[7:5] < 3'd5) begin
		cs[address[7:5]] = 1'b0;
	end
	return cs;
endfunction

function automatic logic expected_mem_select_n();
	return !(!address_enable_n && io_read_n && io_write_n);
endfunction

function automatic data_t ems_register_read(input logic [1:0] idx);
	if (m_en[idx]) begin
		return {2'b00, m_page[idx]};
	end
	return 8'hff;
endfunction

function automatic phys_addr_t translate_address();
	logic [3:0] base;
	logic [1:0] slot;
	base = (frame_sel == 2'd0) ? 4'ha : (frame_sel == 2'd1) ? 4'hc : 4'hd;
	slot = address[15:14];
	if (io_read_n && io_write_n && address[19:16] == base && m_en[slot]) begin
		return {1'b1, m_page[slot], address[13:0]};
	end
	return {1'b0, address};
endfunction

task automatic reset_model_state();
	for (int i = 0; i < 4; i++) begin
		m_page[i] = '0;
	end
	m_en = 4'b0000;
	m_lpt = 8'hff;
	m_wr_valid = 1'b0;
	m_wr_idx = '0;
	m_wr_page = '0;
	m_wr_en = 1'b0;
	m_bus = '0;
	m_flag = 1'b0;
endtask

// one rising edge with the inputs now on the bus
task automatic step_model_edge();
	logic wr_now;
	logic [1:0] idx;
	logic [5:0] new_page;
	logic new_en;
	idx = address[1:0];
	wr_now = ems_selected() && !io_write_n;
	new_page = m_page[idx];
	new_en = m_en[idx];
	if (data == 8'hff) begin
		new_en = 1'b0;
	end else if (data < 8'h80) begin
		new_page = data[5:0];
		new_en = 1'b1;
	end
	// read-back uses the state from before this edge
	if (ems_selected() && !io_read_n) begin
		m_bus = ems_register_read(idx);
		m_flag = 1'b1;
	end else if (lpt_selected() && !io_read_n) begin
		m_bus = m_lpt;
		m_flag = 1'b1;
	end else begin
		m_bus = '0;
		m_flag = 1'b0;
	end
	if (lpt_selected() && !io_write_n) begin
		m_lpt = data;
	end
	if (m_wr_valid) begin
		m_page[m_wr_idx] = m_wr_page;
		m_en[m_wr_idx] = m_wr_en;
	end
	m_wr_valid = wr_now;
	m_wr_idx = idx;
	m_wr_page = new_page;
	m_wr_en = new_en;
endtask

`endif

//--- tests/peripherals_tb.sv
`timescale 1ns/1ps

module peripherals_tb import chipset_pkg::*; ();

	localparam io_port_t EMS_PORT = 16'h0260;
	localparam io_port_t LPT_PORT = 16'h0378;
	localparam logic [31:0] RAND_SEED = 32'he8082ec1;
	localparam int RESET_CYCLES = 3;
	localparam int DIRECTED_CYCLES = 20;
	localparam int RANDOM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 2);

	logic clock;
	logic reset;
	addr_t address;
	data_t data;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic address_enable_n;
	logic ems_enabled;
	frame_sel_t frame_sel;
	logic dma_cs_n;
	logic pic_cs_n;
	logic pit_cs_n;
	logic ppi_cs_n;
	logic dma_page_cs_n;
	logic mem_select_n;
	phys_addr_t mem_addr;
	data_t data_bus;
	logic data_from_chipset;
	int error_count;
	int check_count;
	int cycle_count;

	`include "peripherals_model.svh"

	peripherals_top #(
		.EMS_BASE(EMS_PORT),
		.LPT_BASE(LPT_PORT)
	) dut (
		.clock(clock),
		.reset(reset),
		.address_i(address),
		.data_i(data),
		.io_read_n_i(io_read_n),
		.io_write_n_i(io_write_n),
		.memory_read_n_i(memory_read_n),
		.address_enable_n_i(address_enable_n),
		.ems_enabled_i(ems_enabled),
		.frame_sel_i(frame_sel),
		.dma_cs_n_o(dma_cs_n),
		.pic_cs_n_o(pic_cs_n),
		.pit_cs_n_o(pit_cs_n),
		.ppi_cs_n_o(ppi_cs_n),
		.dma_page_cs_n_o(dma_page_cs_n),
		.mem_select_n_o(mem_select_n),
		.mem_addr_o(mem_addr),
		.data_bus_o(data_bus),
		.data_from_chipset_o(data_from_chipset)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (expected === actual) else begin
			error_count++;
			$display("error: %s at cycle %0d expected %h actual %h",
				name, cycle_count, expected, actual);
		end
	endtask

	task automatic set_idle();
		address = '0;
		data = '0;
		io_read_n = 1'b1;
		io_write_n = 1'b1;
		memory_read_n = 1'b1;
		address_enable_n = 1'b1;
	endtask

	// registered outputs are stable in the low half of the clock
	task automatic check_readback();
		@(negedge clock);
		check_value("data_bus", 32'(m_bus), 32'(data_bus));
		check_value("data_from_chipset", 32'(m_flag), 32'(data_from_chipset));
	endtask

	task automatic check_decode_and_step();
		#1;
		check_value("chip_selects", 32'(expected_chip_selects()),
			32'({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}));
		check_value("mem_select_n", 32'(expected_mem_select_n()), 32'(mem_select_n));
		check_value("mem_addr", 32'(translate_address()), 32'(mem_addr));
		step_model_edge();
	endtask

	task automatic directed_io(input io_port_t port, input data_t value, input logic is_write);
		check_readback();
		set_idle();
		address_enable_n = 1'b0;
		address = {4'h0, port};
		data = value;
		io_write_n = !is_write;
		io_read_n = is_write;
		check_decode_and_step();
	endtask

	// disable code, valid page or a keep value
	function automatic data_t ems_write_byte();
		int pick;
		pick = $urandom_range(0, 3);
		if (pick == 0) begin
			return 8'hff;
		end else if (pick == 3) begin
			return data_t'($urandom_range(128, 254));
		end
		return data_t'($urandom_range(0, 127));
	endfunction

	task automatic random_stimulus();
		int kind;
		int pick;
		ems_index_t idx;
		kind = $urandom_range(0, 15);
		pick = $urandom_range(0, 2);
		idx = ems_index_t'($urandom_range(0, 3));
		set_idle();
		address_enable_n = 1'b0;
		address = addr_t'($urandom);
		data = data_t'($urandom);
		case (kind)
			0, 1: begin
				address = {4'h0, EMS_PORT[15:2], idx};
				data = ems_write_byte();
				io_write_n = 1'b0;
			end
			2, 3: begin
				address = {4'h0, EMS_PORT[15:2], idx};
				io_read_n = 1'b0;
			end
			4: begin
				address = {4'h0, LPT_PORT};
				io_write_n = 1'b0;
			end
			5: begin
				address = {4'h0, LPT_PORT};
				io_read_n = 1'b0;
			end
			6, 7: begin
				address = {10'h000, 10'($urandom_range(0, 1023))};
				io_read_n = kind[0];
				io_write_n = !kind[0];
			end
			8, 9: begin
				address[19:16] = (pick == 0) ? 4'ha : (pick == 1) ? 4'hc : 4'hd;
				memory_read_n = 1'b0;
			end
			10: begin
				memory_read_n = 1'b0;
			end
			11: begin
				if ($urandom_range(0, 3) == 0) begin
					ems_enabled = !ems_enabled;
				end
			end
			12: begin
				frame_sel = frame_sel_t'($urandom_range(0, 3));
			end
			13: begin
				// i/o cycles inside a frame must pass through untranslated
				address[19:16] = (pick == 0) ? 4'ha : (pick == 1) ? 4'hc : 4'hd;
				address_enable_n = 1'($urandom_range(0, 1));
				io_read_n = 1'($urandom_range(0, 1));
				io_write_n = 1'($urandom_range(0, 1));
			end
			default: begin
				address_enable_n = 1'b1;
			end
		endcase
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		error_count = 0;
		check_count = 0;
		reset = 1'b1;
		set_idle();
		ems_enabled = 1'b1;
		frame_sel = 2'd0;
		reset_model_state();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		step_model_edge();
		for (int i = 0; i < 4; i++) begin
			directed_io(EMS_PORT + io_port_t'(i), 8'h00, 1'b0);
		end
		directed_io(LPT_PORT, 8'h00, 1'b0);
		// back to back writes to all four registers
		directed_io(EMS_PORT, 8'h45, 1'b1);
		directed_io(EMS_PORT + 16'd1, 8'h3f, 1'b1);
		directed_io(EMS_PORT + 16'd2, 8'hff, 1'b1);
		directed_io(EMS_PORT + 16'd3, 8'h90, 1'b1);
		for (int i = 0; i < 4; i++) begin
			directed_io(EMS_PORT + io_port_t'(i), 8'h00, 1'b0);
		end
		directed_io(LPT_PORT, 8'ha5, 1'b1);
		directed_io(LPT_PORT, 8'h00, 1'b0);
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			check_readback();
			random_stimulus();
			check_decode_and_step();
		end
		check_readback();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
